// ==== include/soc_macros.svh ====
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

`define SOC_WORD_WIDTH      32

// address map
`define CLINT_BASE          32'h0200_0000
`define CLINT_MASK          32'hFFFF_0000   // 64 KiB window
`define DTUBE_BASE          32'h1000_0000
`define DTUBE_MASK          32'hFFFF_F000   // 4 KiB window

// clint register offsets, low words, high word at +4
`define CLINT_MSIP_OFS      16'h0000
`define CLINT_MTIMECMP_OFS  16'h4000
`define CLINT_MTIME_OFS     16'hBFF8

`define DTUBE_DIGITS        6               // digit n at byte offset 4n

`define HTRANS_IDLE         2'b00
`define HTRANS_NONSEQ       2'b10
`define HRESP_OKAY          2'b00
`define HRESP_ERROR         2'b01

`endif

// ==== verilog/soc_pkg.sv ====
`include "soc_macros.svh"

package soc_pkg;

    typedef logic [`SOC_WORD_WIDTH - 1 : 0] word_t;
    typedef logic [`SOC_WORD_WIDTH - 1 : 0] addr_t;
    typedef logic [1 : 0]                   htrans_t;
    typedef logic [1 : 0]                   hresp_t;
    typedef logic [7 : 0]                   seg_t;      // active low, dp in bit 7
    typedef logic [4 : 0]                   digit_t;    // dp flag + hex value
    typedef logic [63 : 0]                  mtime_t;

    typedef struct packed {
        addr_t   haddr;
        logic    hwrite;
        htrans_t htrans;
    } ahb_req_t;

    typedef struct packed {
        word_t  hrdata;
        logic   hready;
        hresp_t hresp;
    } ahb_rsp_t;

    typedef struct packed {
        logic clint;
        logic dtube;
        logic none;     // unmapped
    } slave_sel_t;

endpackage

// ==== verilog/ahb_bus_decoder.sv ====
`include "soc_macros.svh"

module ahb_bus_decoder (
    input  logic              clk,
    input  logic              rst,
    input  soc_pkg::ahb_req_t req,
    input  soc_pkg::ahb_rsp_t clint_rsp,
    input  soc_pkg::ahb_rsp_t dtube_rsp,
    output logic              hsel_clint,
    output logic              hsel_dtube,
    output soc_pkg::ahb_rsp_t rsp
);

    soc_pkg::slave_sel_t sel_addr;     // address phase, combinational
    soc_pkg::slave_sel_t sel_data;     // data phase

    always_comb begin
        sel_addr = '0;
        if (req.htrans == `HTRANS_NONSEQ) begin
            if ((req.haddr & `CLINT_MASK) == `CLINT_BASE) begin
                sel_addr.clint = 1'b1;
            end else if ((req.haddr & `DTUBE_MASK) == `DTUBE_BASE) begin
                sel_addr.dtube = 1'b1;
            end else begin
                sel_addr.none = 1'b1;   // plic, spi, uart space lands here too
            end
        end
    end

    assign hsel_clint = sel_addr.clint;
    assign hsel_dtube = sel_addr.dtube;

    // address phase completes only while hready is high
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_data <= '0;
        end else if (rsp.hready) begin
            sel_data <= sel_addr;
        end
    end

    always_comb begin
        rsp = '{hrdata: '0, hready: 1'b1, hresp: `HRESP_OKAY};   // idle
        if (sel_data.clint) begin
            rsp = clint_rsp;
        end else if (sel_data.dtube) begin
            rsp = dtube_rsp;
        end else if (sel_data.none) begin
            // single cycle error, hready stays high
            rsp.hresp = `HRESP_ERROR;
        end
    end

    a_sel_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(sel_data)
    ) else $error("data phase select not one-hot");

endmodule

// ==== verilog/clint.sv ====
`include "soc_macros.svh"

module clint (
    input  logic              clk,
    input  logic              rst,
    input  logic              rtc_toggle,   // async
    input  logic              hsel,
    input  soc_pkg::ahb_req_t req,
    input  soc_pkg::word_t    hwdata,
    output soc_pkg::ahb_rsp_t rsp,
    output logic              irq_timer,
    output logic              irq_software
);

    logic            rtc_s1;
    logic            rtc_s2;
    logic            rtc_s3;
    logic            rtc_edge;
    logic            ap_valid;
    logic            ap_write;
    logic [15 : 0]   ap_ofs;
    logic            wr_en;
    logic            rd_en;
    logic            msip;
    soc_pkg::mtime_t mtime;
    soc_pkg::mtime_t mtimecmp;
    soc_pkg::word_t  rd_data;

    // 2-flop synchroniser plus one stage for edge detect
    always_ff @(posedge clk) begin
        if (rst) begin
            rtc_s1 <= 1'b0;
            rtc_s2 <= 1'b0;
            rtc_s3 <= 1'b0;
        end else begin
            rtc_s1 <= rtc_toggle;
            rtc_s2 <= rtc_s1;
            rtc_s3 <= rtc_s2;
        end
    end

    assign rtc_edge = rtc_s2 ^ rtc_s3;  // both edges count

    always_ff @(posedge clk) begin
        if (rst) begin
            ap_valid <= 1'b0;
        end else begin
            ap_valid <= hsel && (req.htrans == `HTRANS_NONSEQ);
        end
    end

    always_ff @(posedge clk) begin
        ap_write <= req.hwrite;
        ap_ofs   <= req.haddr[15 : 0] & 16'hFFFC;  // word aligned
    end

    assign wr_en = ap_valid && ap_write;
    assign rd_en = ap_valid && !ap_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            msip     <= 1'b0;
            mtimecmp <= '1;
        end else if (wr_en) begin
            if (ap_ofs == `CLINT_MSIP_OFS) msip <= hwdata[0];
            if (ap_ofs == `CLINT_MTIMECMP_OFS) mtimecmp[31 : 0] <= hwdata;
            if (ap_ofs == `CLINT_MTIMECMP_OFS + 16'd4) mtimecmp[63 : 32] <= hwdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtime <= '0;
        end else if (wr_en && ap_ofs == `CLINT_MTIME_OFS) begin
            mtime[31 : 0] <= hwdata;
        end else if (wr_en && ap_ofs == `CLINT_MTIME_OFS + 16'd4) begin
            mtime[63 : 32] <= hwdata;
        end else if (rtc_edge) begin
            mtime <= mtime + 64'd1;     // a write wins over the tick
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            irq_timer <= 1'b0;
        end else begin
            irq_timer <= (mtime >= mtimecmp);
        end
    end

    assign irq_software = msip;

    always_comb begin
        rd_data = '0;
        if (rd_en) begin
            case (ap_ofs)
                `CLINT_MSIP_OFS:                rd_data = {31'b0, msip};
                `CLINT_MTIMECMP_OFS:            rd_data = mtimecmp[31 : 0];
                `CLINT_MTIMECMP_OFS + 16'd4:    rd_data = mtimecmp[63 : 32];
                `CLINT_MTIME_OFS:               rd_data = mtime[31 : 0];
                `CLINT_MTIME_OFS + 16'd4:       rd_data = mtime[63 : 32];
                default:                        rd_data = '0;
            endcase
        end
    end

    assign rsp = '{hrdata: rd_data, hready: 1'b1, hresp: `HRESP_OKAY};

    // decoder never waits on this slave
    a_no_wait: assert property (@(posedge clk) disable iff (rst) rsp.hready)
        else $error("clint stalled the bus");

    a_irq_after_rst: assert property (@(posedge clk) rst |=> !irq_timer)
        else $error("irq_timer high right after reset");

endmodule

// ==== verilog/dtube.sv ====
`include "soc_macros.svh"

module dtube (
    input  logic              clk,
    input  logic              rst,
    input  logic              hsel,
    input  soc_pkg::ahb_req_t req,
    input  soc_pkg::word_t    hwdata,
    output soc_pkg::ahb_rsp_t rsp,
    output soc_pkg::seg_t     hex [`DTUBE_DIGITS]
);

    logic             ap_valid;
    logic             ap_write;
    logic [9 : 0]     ap_idx;       // word index inside the 4 KiB window
    logic             hit;
    soc_pkg::digit_t  digit [`DTUBE_DIGITS];
    soc_pkg::word_t   rd_data;

    // active high gfedcba, then inverted with the point on top
    function automatic soc_pkg::seg_t seg_of(input soc_pkg::digit_t d);
        logic [6 : 0] font;
        case (d[3 : 0])
            4'h0: font = 7'h3F;
            4'h1: font = 7'h06;
            4'h2: font = 7'h5B;
            4'h3: font = 7'h4F;
            4'h4: font = 7'h66;
            4'h5: font = 7'h6D;
            4'h6: font = 7'h7D;
            4'h7: font = 7'h07;
            4'h8: font = 7'h7F;
            4'h9: font = 7'h6F;
            4'hA: font = 7'h77;
            4'hB: font = 7'h7C;
            4'hC: font = 7'h39;
            4'hD: font = 7'h5E;
            4'hE: font = 7'h79;
            default: font = 7'h71;  // F
        endcase
        return ~{d[4], font};
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            ap_valid <= 1'b0;
        end else begin
            ap_valid <= hsel && (req.htrans == `HTRANS_NONSEQ);
        end
    end

    always_ff @(posedge clk) begin
        ap_write <= req.hwrite;
        ap_idx   <= req.haddr[11 : 2];
    end

    assign hit = ap_valid && (ap_idx < `DTUBE_DIGITS);  // rest of window is dead space

    for (genvar i = 0; i < `DTUBE_DIGITS; i++) begin : g_digit
        always_ff @(posedge clk) begin
            if (rst) begin
                digit[i] <= '0;
            end else if (hit && ap_write && ap_idx[2 : 0] == i) begin
                digit[i] <= hwdata[4 : 0];
            end
        end

        always_ff @(posedge clk) begin
            if (rst) hex[i] <= seg_of('0);
            else hex[i] <= seg_of(digit[i]);   // one cycle behind the digit
        end
    end

    assign rd_data = (hit && !ap_write) ? soc_pkg::word_t'(digit[ap_idx[2 : 0]]) : '0;
    assign rsp = '{hrdata: rd_data, hready: 1'b1, hresp: `HRESP_OKAY};

endmodule

// ==== verilog/soc_periph_top.sv ====
`include "soc_macros.svh"

module soc_periph_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              rtc_toggle,
    input  soc_pkg::ahb_req_t req,
    input  soc_pkg::word_t    hwdata,
    output soc_pkg::ahb_rsp_t rsp,
    output logic              irq_timer,
    output logic              irq_software,
    output soc_pkg::seg_t     hex [`DTUBE_DIGITS]
);

    logic              hsel_clint;
    logic              hsel_dtube;
    soc_pkg::ahb_rsp_t clint_rsp;
    soc_pkg::ahb_rsp_t dtube_rsp;

    ahb_bus_decoder u_ahb_bus_decoder (
        .clk            (clk            ),
        .rst            (rst            ),
        .req            (req            ),
        .clint_rsp      (clint_rsp      ),
        .dtube_rsp      (dtube_rsp      ),
        .hsel_clint     (hsel_clint     ),
        .hsel_dtube     (hsel_dtube     ),
        .rsp            (rsp            )
    );

    clint u_clint (
        .clk            (clk            ),
        .rst            (rst            ),
        .rtc_toggle     (rtc_toggle     ),   // async
        .hsel           (hsel_clint     ),
        .req            (req            ),
        .hwdata         (hwdata         ),
        .rsp            (clint_rsp      ),
        .irq_timer      (irq_timer      ),
        .irq_software   (irq_software   )
    );

    dtube u_dtube (
        .clk            (clk            ),
        .rst            (rst            ),
        .hsel           (hsel_dtube     ),
        .req            (req            ),
        .hwdata         (hwdata         ),
        .rsp            (dtube_rsp      ),
        .hex            (hex            )
    );

endmodule

// ==== testbench/soc_periph_tb.sv ====
`include "soc_macros.svh"

module soc_periph_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [2 : 0] OP_WRITE  = 3'd0;
    localparam logic [2 : 0] OP_READ   = 3'd1;
    localparam logic [2 : 0] OP_TOGGLE = 3'd2;
    localparam logic [2 : 0] OP_IRQ    = 3'd3;
    localparam logic [2 : 0] OP_HEX    = 3'd4;
    localparam soc_pkg::addr_t UNMAPPED = 32'h3000_0000;
    localparam soc_pkg::addr_t PLIC_ADDR = 32'h0C00_0000;  // plic is not built

    typedef struct packed {
        logic [2 : 0]    op;
        soc_pkg::addr_t  addr;      // irq select or digit index for checks
        soc_pkg::word_t  data;      // write data, toggle count or wait limit
        soc_pkg::word_t  exp_data;
        soc_pkg::hresp_t exp_resp;
    } step_t;

    logic              clk;
    logic              rst;
    logic              rtc_toggle;
    soc_pkg::ahb_req_t req;
    soc_pkg::word_t    hwdata;
    soc_pkg::ahb_rsp_t rsp;
    logic              irq_timer;
    logic              irq_software;
    soc_pkg::seg_t     hex [`DTUBE_DIGITS];

    step_t          steps [$];
    logic [31 : 0]  lfsr_state;
    int             tests;
    int             checks;
    int             errors;
    int             test_errors;
    soc_pkg::word_t digits [`DTUBE_DIGITS];
    // lit segments per hex value
    string font [16] = '{"abcdef", "bc", "abdeg", "abcdg", "bcfg", "acdfg", "acdefg",
        "abc", "abcdefg", "abcdfg", "abcefg", "cdefg", "adef", "bcdeg", "adefg", "aefg"};

    soc_periph_top soc_periph_top_i (
        .clk          (clk),
        .rst          (rst),
        .rtc_toggle   (rtc_toggle),
        .req          (req),
        .hwdata       (hwdata),
        .rsp          (rsp),
        .irq_timer    (irq_timer),
        .irq_software (irq_software),
        .hex          (hex)
    );

    always #10 clk = ~clk;

    function automatic logic [31 : 0] lfsr_next(input logic [31 : 0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31 : 0] random_bits(input int n);
        logic [31 : 0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30 : 0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic soc_pkg::seg_t expected_seg(input logic [4 : 0] d);
        soc_pkg::seg_t seg;
        string lit;
        seg = 8'hFF;    // active low, all dark
        lit = font[d[3 : 0]];
        for (int i = 0; i < lit.len(); i++) begin
            seg[lit[i] - 8'h61] = 1'b0;
        end
        if (d[4]) seg[7] = 1'b0;
        return seg;
    endfunction

    function automatic void add_step(input logic [2 : 0] op, input soc_pkg::addr_t addr,
        input soc_pkg::word_t data, input soc_pkg::word_t exp_data,
        input soc_pkg::hresp_t exp_resp);
        steps.push_back('{op: op, addr: addr, data: data, exp_data: exp_data,
            exp_resp: exp_resp});
    endfunction

    // address phase now, sample in the data phase, return on the following falling edge
    task automatic bus_cycle(input soc_pkg::addr_t addr, input logic write,
        input soc_pkg::word_t data, output soc_pkg::word_t rdata,
        output soc_pkg::hresp_t resp);
        req = '{haddr: addr, hwrite: write, htrans: `HTRANS_NONSEQ};
        @(negedge clk);
        rdata  = rsp.hrdata;
        resp   = rsp.hresp;
        check_value("hready", 32'(rsp.hready), 32'd1);  // zero wait slaves
        req    = '{haddr: '0, hwrite: 1'b0, htrans: `HTRANS_IDLE};
        hwdata = write ? data : '0;     // held until after the commit edge
        @(negedge clk);
    endtask

    task automatic bus_write(input soc_pkg::addr_t addr, input soc_pkg::word_t data,
        output soc_pkg::word_t rdata, output soc_pkg::hresp_t resp);
        bus_cycle(addr, 1'b1, data, rdata, resp);
    endtask

    task automatic bus_read(input soc_pkg::addr_t addr, output soc_pkg::word_t rdata,
        output soc_pkg::hresp_t resp);
        bus_cycle(addr, 1'b0, '0, rdata, resp);
    endtask

    task automatic check_value(input string name, input logic [31 : 0] got,
        input logic [31 : 0] exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic wait_irq(input logic which, input logic level, input int limit);
        int  n;
        logic cur;
        string name;
        n    = 0;
        name = which ? "irq_software" : "irq_timer";
        cur  = which ? irq_software : irq_timer;
        while (cur !== level && n < limit) begin
            @(negedge clk);
            n++;
            cur = which ? irq_software : irq_timer;
        end
        checks++;
        if (cur !== level && limit == 0) begin
            $display("mismatch at %0t ns: %s got %b expected %b", $time, name, cur, level);
            test_errors++;
        end else if (cur !== level) begin
            $display("timeout at %0t ns: %s did not go to %b within %0d cycles",
                $time, name, level, limit);
            test_errors++;
        end
    endtask

    task automatic run_steps(input string name);
        soc_pkg::word_t  rdata;
        soc_pkg::hresp_t resp;
        step_t           s;
        test_errors = 0;
        foreach (steps[i]) begin
            s = steps[i];
            case (s.op)
                OP_WRITE: begin
                    bus_write(s.addr, s.data, rdata, resp);
                    check_value("hrdata", rdata, s.exp_data);
                    check_value("hresp", 32'(resp), 32'(s.exp_resp));
                end
                OP_READ: begin
                    bus_read(s.addr, rdata, resp);
                    check_value("hrdata", rdata, s.exp_data);
                    check_value("hresp", 32'(resp), 32'(s.exp_resp));
                end
                OP_TOGGLE: begin
                    repeat (s.data) begin
                        rtc_toggle = ~rtc_toggle;
                        repeat (6) @(negedge clk);     // toggle spacing
                    end
                end
                OP_IRQ: wait_irq(s.addr[0], s.exp_data[0], int'(s.data));
                OP_HEX: check_value($sformatf("hex[%0d]", s.addr), 32'(hex[s.addr]),
                    s.exp_data);
                default: begin
                    $display("step %0d of test %s has an unknown operation", i, name);
                    test_errors++;
                end
            endcase
        end
        steps.delete();
        tests++;
        errors += test_errors;
        $display("test %0d %s: %s, %0d errors", tests, name,
            test_errors == 0 ? "ok" : "wrong", test_errors);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        rtc_toggle = 1'b0;
        req        = '{haddr: '0, hwrite: 1'b0, htrans: `HTRANS_IDLE};
        hwdata     = '0;
        lfsr_state = 32'd92793;
        tests      = 0;
        checks     = 0;
        errors     = 0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < `DTUBE_DIGITS; i++) begin
            add_step(OP_HEX, i, 0, 32'(expected_seg(5'd0)), `HRESP_OKAY);
        end
        add_step(OP_IRQ, 0, 0, 0, `HRESP_OKAY);
        add_step(OP_IRQ, 1, 0, 0, `HRESP_OKAY);
        add_step(OP_READ, `CLINT_BASE + `CLINT_MTIMECMP_OFS, 0, '1, `HRESP_OKAY);
        add_step(OP_READ, `CLINT_BASE + `CLINT_MTIMECMP_OFS + 4, 0, '1, `HRESP_OKAY);
        run_steps("reset values");

        for (int i = 0; i < `DTUBE_DIGITS; i++) begin
            digits[i] = random_bits(5);
            add_step(OP_WRITE, `DTUBE_BASE + 4 * i, digits[i], 0, `HRESP_OKAY);
        end
        for (int i = 0; i < `DTUBE_DIGITS; i++) begin
            add_step(OP_READ, `DTUBE_BASE + 4 * i, 0, digits[i], `HRESP_OKAY);
        end
        for (int i = 0; i < `DTUBE_DIGITS; i++) begin
            add_step(OP_HEX, i, 0, 32'(expected_seg(digits[i][4 : 0])), `HRESP_OKAY);
        end
        run_steps("display");

        add_step(OP_WRITE, `CLINT_BASE + `CLINT_MSIP_OFS, 1, 0, `HRESP_OKAY);
        add_step(OP_IRQ, 1, 4, 1, `HRESP_OKAY);
        add_step(OP_READ, `CLINT_BASE + `CLINT_MSIP_OFS, 0, 1, `HRESP_OKAY);
        add_step(OP_WRITE, `CLINT_BASE + `CLINT_MSIP_OFS, 0, 0, `HRESP_OKAY);
        add_step(OP_IRQ, 1, 4, 0, `HRESP_OKAY);
        add_step(OP_READ, `CLINT_BASE + `CLINT_MSIP_OFS, 0, 0, `HRESP_OKAY);
        run_steps("software interrupt");

        add_step(OP_WRITE, `CLINT_BASE + `CLINT_MTIME_OFS, 0, 0, `HRESP_OKAY);
        add_step(OP_WRITE, `CLINT_BASE + `CLINT_MTIME_OFS + 4, 0, 0, `HRESP_OKAY);
        add_step(OP_TOGGLE, 0, 10, 0, `HRESP_OKAY);
        add_step(OP_READ, `CLINT_BASE + `CLINT_MTIME_OFS, 0, 10, `HRESP_OKAY);
        add_step(OP_READ, `CLINT_BASE + `CLINT_MTIME_OFS + 4, 0, 0, `HRESP_OKAY);
        run_steps("timer counting");

        // mtime is 10 here, compare at 13
        add_step(OP_WRITE, `CLINT_BASE + `CLINT_MTIMECMP_OFS, 13, 0, `HRESP_OKAY);
        add_step(OP_WRITE, `CLINT_BASE + `CLINT_MTIMECMP_OFS + 4, 0, 0, `HRESP_OKAY);
        add_step(OP_IRQ, 0, 0, 0, `HRESP_OKAY);
        add_step(OP_TOGGLE, 0, 2, 0, `HRESP_OKAY);
        add_step(OP_IRQ, 0, 0, 0, `HRESP_OKAY);
        add_step(OP_TOGGLE, 0, 1, 0, `HRESP_OKAY);
        add_step(OP_IRQ, 0, 20, 1, `HRESP_OKAY);
        add_step(OP_WRITE, `CLINT_BASE + `CLINT_MTIMECMP_OFS + 4, '1, 0, `HRESP_OKAY);
        add_step(OP_IRQ, 0, 20, 0, `HRESP_OKAY);
        run_steps("timer compare");

        add_step(OP_WRITE, UNMAPPED, 32'h1F, 0, `HRESP_ERROR);
        add_step(OP_READ, UNMAPPED, 0, 0, `HRESP_ERROR);
        add_step(OP_READ, PLIC_ADDR, 0, 0, `HRESP_ERROR);
        add_step(OP_READ, `DTUBE_BASE, 0, digits[0], `HRESP_OKAY);
        add_step(OP_HEX, 0, 0, 32'(expected_seg(digits[0][4 : 0])), `HRESP_OKAY);
        run_steps("error response");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
verilog/soc_pkg.sv
verilog/ahb_bus_decoder.sv
verilog/clint.sv
verilog/dtube.sv
verilog/soc_periph_top.sv
testbench/soc_periph_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= soc_periph_tb
FLIST     ?= sim.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
